/* files.f */
hw/rv_m_pkg.sv
hw/mdu_pkg.sv
hw/m_op_decode.sv
hw/alu_div_slow.sv
hw/alu_mul_slow.sv
hw/mdu_result_sel.sv
hw/mdu_top.sv
test/mdu_tb.sv

/* run.sh */
#!/bin/sh
# build the MDU testbench with Verilator, run it, then scan the log
verilator --binary --timing --assert -Wno-fatal --top-module mdu_tb -f files.f -o mdu_sim \
  > build.log 2>&1 && ./obj_dir/mdu_sim > sim.log 2>&1 || { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* test/mdu_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module mdu_tb import rv_m_pkg::*; ();

  localparam int WAIT_LIMIT = 200;  // longest op is 67 cycles

  logic            clk = 1'b0;
  logic            rst;
  logic            start_i;
  m_op_e           op_i;
  logic [XLEN-1:0] rs1_i;
  logic [XLEN-1:0] rs2_i;
  logic            busy_o;
  logic            done_o;
  logic [XLEN-1:0] result_o;

  int seed = 32'h10ba_b053;
  int mismatches = 0;
  int flag_errs = 0;
  int timeouts = 0;
  int stray_dones = 0;
  int ops_started = 0;
  int done_seen = 0;

  // expected results, oldest first
  string           exp_name_q[$];
  m_op_e           exp_op_q[$];
  logic [XLEN-1:0] exp_val_q[$];

  mdu_top i_mdu_top (
    .clk     (clk),
    .rst     (rst),
    .start_i (start_i),
    .op_i    (op_i),
    .rs1_i   (rs1_i),
    .rs2_i   (rs2_i),
    .busy_o  (busy_o),
    .done_o  (done_o),
    .result_o(result_o)
  );

  always #10 clk = ~clk;

  // RISC-V M-extension result
  function automatic logic [XLEN-1:0] mdu_model(input m_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] ea;
    logic [2*XLEN-1:0] eb;
    logic [2*XLEN-1:0] prod;
    logic [WLEN-1:0]   aw;
    logic [WLEN-1:0]   bw;
    logic [WLEN-1:0]   w;
    logic              ovf;
    logic              ovf_w;
    logic [XLEN-1:0]   r;
    r     = '0;
    w     = '0;
    aw    = a[WLEN-1:0];
    bw    = b[WLEN-1:0];
    ea    = (op == MULH || op == MULHSU) ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
    eb    = (op == MULH) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
    prod  = ea * eb;  // low 128 bits are right for any sign mix
    ovf   = (a == {1'b1, {(XLEN-1){1'b0}}}) && (&b);
    ovf_w = (aw == {1'b1, {(WLEN-1){1'b0}}}) && (&bw);
    case (op)
      MUL: r = prod[XLEN-1:0];
      MULH, MULHSU, MULHU: r = prod[2*XLEN-1:XLEN];
      DIV: begin
        if (b == '0) r = '1;
        else if (ovf) r = a;
        else r = $signed(a) / $signed(b);
      end
      DIVU: begin
        if (b == '0) r = '1;
        else r = a / b;
      end
      REM: begin
        if (b == '0) r = a;
        else if (ovf) r = '0;
        else r = $signed(a) % $signed(b);
      end
      REMU: begin
        if (b == '0) r = a;
        else r = a % b;
      end
      MULW: w = prod[WLEN-1:0];
      DIVW: begin
        if (bw == '0) w = '1;
        else if (ovf_w) w = aw;
        else w = $signed(aw) / $signed(bw);
      end
      DIVUW: begin
        if (bw == '0) w = '1;
        else w = aw / bw;
      end
      REMW: begin
        if (bw == '0) w = aw;
        else if (ovf_w) w = '0;
        else w = $signed(aw) % $signed(bw);
      end
      REMUW: begin
        if (bw == '0) w = aw;
        else w = aw % bw;
      end
      default: r = '0;
    endcase
    if (op inside {MULW, DIVW, DIVUW, REMW, REMUW}) r = {{(XLEN-WLEN){w[WLEN-1]}}, w};
    return r;
  endfunction

  task automatic check_result(input string name, input m_op_e op,
                              input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s op=%s expected=%h actual=%h", name, op.name(), exp, act);
      mismatches++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("MISMATCH %s expected=%b actual=%b", name, exp, act);
      flag_errs++;
    end
  endtask

  // pulses start for one cycle, called and returns at a falling edge
  task automatic issue_op(input string name, input m_op_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
    exp_name_q.push_back(name);
    exp_op_q.push_back(op);
    exp_val_q.push_back(mdu_model(op, a, b));
    ops_started++;
    start_i = 1'b1;
    op_i    = op;
    rs1_i   = a;
    rs2_i   = b;
    @(negedge clk);
    start_i = 1'b0;
  endtask

  task automatic wait_done(input string name);
    int cnt;
    cnt = 0;
    while (!done_o && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!done_o) begin
      $display("ERROR %s: no done_o pulse within %0d cycles", name, WAIT_LIMIT);
      timeouts++;
    end
  endtask

  task automatic run_op(input string name, input m_op_e op, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b);
    issue_op(name, op, a, b);
    check_flag({name, " busy"}, 1'b1, busy_o);
    wait_done(name);
    if (done_o) begin
      check_flag({name, " busy at done"}, 1'b0, busy_o);
      @(negedge clk);
      check_flag({name, " done width"}, 1'b0, done_o);
      check_result({name, " held"}, op, mdu_model(op, a, b), result_o);
    end
  endtask

  // compare process, one expected entry per done pulse
  always @(negedge clk) begin
    if (!rst && done_o) begin
      done_seen++;
      if (exp_val_q.size() == 0) begin
        $display("ERROR done_o pulsed with no operation outstanding");
        stray_dones++;
      end else begin
        check_result(exp_name_q.pop_front(), exp_op_q.pop_front(), exp_val_q.pop_front(),
                     result_o);
      end
    end
  end

  initial begin
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [31:0]     r;
    int              cnt;
    rst     = 1'b1;
    start_i = 1'b0;
    op_i    = MUL;
    rs1_i   = '0;
    rs2_i   = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    // idle after reset
    repeat (6) begin
      @(negedge clk);
      check_flag("reset busy", 1'b0, busy_o);
      check_flag("reset done", 1'b0, done_o);
      check_result("reset result", MUL, '0, result_o);
    end

    // random operands, all opcodes
    for (int k = 0; k < 13; k++) begin
      for (int i = 0; i < 6; i++) begin
        a = {$random(seed), $random(seed)};
        b = {$random(seed), $random(seed)};
        r = $random(seed);
        if (i % 2 == 1) b = b >> r[5:0];  // smaller divisors too
        run_op("random", m_op_e'(k), a, b);
      end
    end

    // divide by zero, upper bits set for the W forms
    a = {$random(seed), $random(seed)};
    run_op("div by zero", DIV, a, '0);
    run_op("div by zero", DIVU, a, '0);
    run_op("div by zero", REM, a, '0);
    run_op("div by zero", REMU, a, '0);
    run_op("div by zero", DIVW, a, 64'hdead_beef_0000_0000);
    run_op("div by zero", DIVUW, a, 64'hdead_beef_0000_0000);
    run_op("div by zero", REMW, a, 64'h0000_0001_0000_0000);
    run_op("div by zero", REMUW, a, 64'h0000_0001_0000_0000);

    // signed overflow
    run_op("overflow", DIV, 64'h8000_0000_0000_0000, '1);
    run_op("overflow", REM, 64'h8000_0000_0000_0000, '1);
    run_op("overflow", DIVW, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
    run_op("overflow", REMW, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);

    // remainder hits +/- divisor before the correction step
    run_op("correction", DIV, 64'd6, 64'd3);
    run_op("correction", REM, 64'd6, 64'd3);
    run_op("correction", DIV, -64'sd6, 64'd3);
    run_op("correction", REM, -64'sd6, 64'd3);
    run_op("correction", DIV, 64'd6, -64'sd3);
    run_op("correction", DIV, -64'sd6, -64'sd3);
    run_op("correction", DIVU, 64'd6, 64'd3);
    run_op("correction", REMU, 64'd6, 64'd3);
    run_op("correction", DIVW, 64'h0000_0000_ffff_fffa, 64'd3);
    run_op("correction", REMW, 64'h0000_0000_ffff_fffa, 64'd3);

    // second strobe while busy must be dropped
    issue_op("ignored start", DIV, 64'd1000, 64'd7);
    repeat (5) @(negedge clk);
    check_flag("ignored start busy", 1'b1, busy_o);
    start_i = 1'b1;
    op_i    = MULHU;
    rs1_i   = '1;
    rs2_i   = '1;
    @(negedge clk);
    start_i = 1'b0;
    wait_done("ignored start");
    @(negedge clk);
    cnt = 0;
    while (!done_o && cnt < WAIT_LIMIT) begin  // no second done may follow
      @(negedge clk);
      cnt++;
    end

    repeat (3) @(negedge clk);
    if (done_seen != ops_started) begin
      $display("MISMATCH done count expected=%0d actual=%0d", ops_started, done_seen);
      flag_errs++;
    end
    $display("errors: %0d mismatches, %0d flag errors, %0d timeouts, %0d stray done pulses",
             mismatches, flag_errs, timeouts, stray_dones);
    if (mismatches + flag_errs + timeouts + stray_dones == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/mdu_top.sv */
`default_nettype none
`timescale 1ns/1ns

module mdu_top import rv_m_pkg::*; import mdu_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            start_i,
  input  wire m_op_e           op_i,
  input  wire logic [XLEN-1:0] rs1_i,
  input  wire logic [XLEN-1:0] rs2_i,
  output logic                 busy_o,
  output logic                 done_o,
  output logic [XLEN-1:0]      result_o
);

  logic              busy_q;
  logic              accept;
  logic              div_start;
  logic              mul_start;
  logic              div_done;
  logic              mul_done;
  div_req_t          div_req;
  mul_req_t          mul_req;
  div_rsp_t          div_rsp;
  sel_ctl_t          sel_ctl_d;
  sel_ctl_t          sel_ctl_q;
  logic [2*XLEN-1:0] product;

  assign busy_o = busy_q & ~done_o;  // drops in the done cycle
  assign accept = start_i & ~busy_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (done_o) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) sel_ctl_q <= sel_ctl_d;
  end

  m_op_decode i_m_op_decode (
    .start_i    (accept),
    .op_i       (op_i),
    .rs1_i      (rs1_i),
    .rs2_i      (rs2_i),
    .div_start_o(div_start),
    .div_req_o  (div_req),
    .mul_start_o(mul_start),
    .mul_req_o  (mul_req),
    .sel_ctl_o  (sel_ctl_d)
  );

  alu_div_slow i_alu_div_slow (
    .clk    (clk),
    .rst    (rst),
    .start_i(div_start),
    .req_i  (div_req),
    .done_o (div_done),
    .rsp_o  (div_rsp)
  );

  alu_mul_slow i_alu_mul_slow (
    .clk      (clk),
    .rst      (rst),
    .start_i  (mul_start),
    .req_i    (mul_req),
    .done_o   (mul_done),
    .product_o(product)
  );

  mdu_result_sel i_mdu_result_sel (
    .clk       (clk),
    .rst       (rst),
    .sel_ctl_i (sel_ctl_q),
    .div_done_i(div_done),
    .div_rsp_i (div_rsp),
    .mul_done_i(mul_done),
    .product_i (product),
    .done_o    (done_o),
    .result_o  (result_o)
  );

  // strobes during busy are dropped
  a_no_start_busy: assert property (@(posedge clk) disable iff (rst) busy_o |-> !start_i)
    else $warning("start_i ignored while busy");

endmodule

`default_nettype wire

/* hw/mdu_result_sel.sv */
`default_nettype none
`timescale 1ns/1ns

module mdu_result_sel import rv_m_pkg::*; import mdu_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire sel_ctl_t          sel_ctl_i,
  input  wire logic              div_done_i,
  input  wire div_rsp_t          div_rsp_i,
  input  wire logic              mul_done_i,
  input  wire logic [2*XLEN-1:0] product_i,
  output logic                   done_o,
  output logic [XLEN-1:0]        result_o
);

  logic [XLEN-1:0] result_q;  // held until the next done
  logic [XLEN-1:0] quot;
  logic [XLEN-1:0] rem;
  logic [XLEN-1:0] raw;
  logic [XLEN-1:0] res_next;
  logic            is_word;

  // RISC-V values for the special cases
  assign quot = sel_ctl_i.div_by_zero ? {XLEN{1'b1}}
              : sel_ctl_i.overflow    ? sel_ctl_i.dividend
              :                         div_rsp_i.quotient;
  assign rem  = sel_ctl_i.div_by_zero ? sel_ctl_i.dividend
              : sel_ctl_i.overflow    ? '0
              :                         div_rsp_i.remainder;

  always_comb begin
    is_word = 1'b0;
    case (sel_ctl_i.op)
      MUL:                     raw = product_i[XLEN-1:0];
      MULH, MULHSU, MULHU:     raw = product_i[2*XLEN-1:XLEN];
      DIV, DIVU:               raw = quot;
      REM, REMU:               raw = rem;
      MULW: begin
        raw     = product_i[XLEN-1:0];
        is_word = 1'b1;
      end
      DIVW, DIVUW: begin
        raw     = quot;
        is_word = 1'b1;
      end
      default: begin
        raw     = rem;  // REMW, REMUW
        is_word = 1'b1;
      end
    endcase
  end

  assign res_next = is_word ? {{(XLEN-WLEN){raw[WLEN-1]}}, raw[WLEN-1:0]} : raw;

  always_ff @(posedge clk) begin
    if (rst) begin
      result_q <= '0;
    end else if (done_o) begin
      result_q <= res_next;
    end
  end

  assign done_o   = div_done_i | mul_done_i;
  assign result_o = done_o ? res_next : result_q;  // valid with the engine's done

endmodule

`default_nettype wire

/* hw/alu_mul_slow.sv */
`default_nettype none
`timescale 1ns/1ns

module alu_mul_slow import rv_m_pkg::*; import mdu_pkg::*; (
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire logic         start_i,
  input  wire mul_req_t     req_i,
  output logic              done_o,
  output logic [2*XLEN-1:0] product_o
);

  mul_state_e                     state_q;
  logic                           done_q;
  logic [$clog2(MUL_STEPS+1)-1:0] cnt_q;
  logic [2*XLEN-1:0]              acc_q;
  logic [2*XLEN-1:0]              mcand_q;   // shifts left
  logic [XLEN-1:0]                mplier_q;  // shifts right
  logic                           neg_q;
  logic [2*XLEN-1:0]              product_q;

  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;

  assign a_neg = req_i.a_signed & req_i.op_a[XLEN-1];
  assign b_neg = req_i.b_signed & req_i.op_b[XLEN-1];
  assign a_mag = a_neg ? -req_i.op_a : req_i.op_a;
  assign b_mag = b_neg ? -req_i.op_b : req_i.op_b;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= MUL_IDLE;
      done_q  <= 1'b0;
      cnt_q   <= '0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        MUL_IDLE: begin
          if (start_i) begin
            cnt_q   <= '0;
            state_q <= MUL_RUN;
          end
        end
        MUL_RUN: begin
          if (cnt_q == MUL_STEPS) begin
            done_q  <= 1'b1;  // sign fixup cycle
            state_q <= MUL_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= MUL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == MUL_IDLE && start_i) begin
      acc_q    <= '0;
      mcand_q  <= {{XLEN{1'b0}}, a_mag};
      mplier_q <= b_mag;
      neg_q    <= a_neg ^ b_neg;
    end else if (state_q == MUL_RUN) begin
      if (cnt_q == MUL_STEPS) begin
        product_q <= neg_q ? -acc_q : acc_q;
      end else begin
        if (mplier_q[0]) acc_q <= acc_q + mcand_q;
        mcand_q  <= mcand_q << 1;
        mplier_q <= mplier_q >> 1;
      end
    end
  end

  assign done_o    = done_q;
  assign product_o = product_q;

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done_o |=> !done_o);

endmodule

`default_nettype wire

/* hw/alu_div_slow.sv */
`default_nettype none
`timescale 1ns/1ns

// nonrestoring two's-complement divider, 64-bit or 32-bit width
module alu_div_slow import rv_m_pkg::*; import mdu_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     start_i,
  input  wire div_req_t req_i,
  output logic          done_o,
  output div_rsp_t      rsp_o
);

  div_state_e             state_q;
  logic                   done_q;
  logic [DIV_STEPS64-1:0] cnt_q;     // one-hot, shifts right each step
  logic                   word_q;
  logic                   z_sign_q;  // dividend sign, for the correction
  logic [2*XLEN+1:0]      s_q;       // partial remainder and quotient digits
  logic [XLEN:0]          d_q;
  logic [XLEN:0]          d_neg_q;
  div_rsp_t               rsp_q;

  logic              z_sign;
  logic              d_sign;
  logic [XLEN:0]     d_ext;
  logic [2*XLEN+1:0] s_load;
  logic              s_sign;
  logic              add_d;
  logic [XLEN:0]     d_sel;
  logic [2*XLEN+1:0] s_next;
  logic [XLEN:0]     rem_raw;
  logic              need_corr;
  logic [XLEN:0]     rem_fix;
  logic [XLEN-1:0]   q_raw;
  logic [XLEN-1:0]   q_fix;

  // operand signs in the requested width
  assign z_sign = req_i.is_signed &
                  (req_i.is_word ? req_i.dividend[WLEN-1] : req_i.dividend[XLEN-1]);
  assign d_sign = req_i.is_signed &
                  (req_i.is_word ? req_i.divisor[WLEN-1] : req_i.divisor[XLEN-1]);

  assign d_ext = req_i.is_word ? {{(XLEN-WLEN+1){d_sign}}, req_i.divisor[WLEN-1:0]}
                               : {d_sign, req_i.divisor};

  // word operands sit in the low 2*WLEN+2 bits
  assign s_load = req_i.is_word
                ? {{(2*XLEN-2*WLEN){1'b0}}, {(WLEN+2){z_sign}}, req_i.dividend[WLEN-1:0]}
                : {{(XLEN+2){z_sign}}, req_i.dividend};

  assign s_sign = word_q ? s_q[2*WLEN+1] : s_q[2*XLEN+1];
  assign add_d  = s_sign ^ (word_q ? d_q[WLEN] : d_q[XLEN]);  // signs differ: add
  assign d_sel  = add_d ? d_q : d_neg_q;

  // shift left by one, add into the upper half, shift in the digit
  assign s_next = word_q
                ? {{(2*XLEN-2*WLEN){1'b0}}, s_q[2*WLEN:WLEN] + d_sel[WLEN:0],
                   s_q[WLEN-1:0], ~add_d}
                : {s_q[2*XLEN:XLEN] + d_sel, s_q[XLEN-1:0], ~add_d};

  assign rem_raw = word_q ? {{(XLEN-WLEN){s_q[2*WLEN+1]}}, s_q[2*WLEN+1:WLEN+1]}
                          : s_q[2*XLEN+1:XLEN+1];

  // remainder with the wrong sign, or equal to +/- divisor
  assign need_corr = ((rem_raw[XLEN] ^ z_sign_q) & (|rem_raw)) |
                     (rem_raw == d_q) | (rem_raw == d_neg_q);

  assign rem_fix = rem_raw + (need_corr ? d_sel : '0);

  // +/-1 digits to two's complement, low bits only
  assign q_raw = word_q ? {{(XLEN-WLEN){1'b0}}, s_q[WLEN-2:0], 1'b1}
                        : {s_q[XLEN-2:0], 1'b1};
  assign q_fix = q_raw + (need_corr ? (add_d ? {XLEN{1'b1}} : {{(XLEN-1){1'b0}}, 1'b1})
                                    : '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= DIV_RST;
      done_q  <= 1'b0;
      cnt_q   <= '0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        DIV_RST: state_q <= DIV_IDLE;
        DIV_IDLE: begin
          if (start_i) begin
            cnt_q   <= req_i.is_word ? (DIV_STEPS64'(1) << (DIV_STEPS32 - 1))
                                     : (DIV_STEPS64'(1) << (DIV_STEPS64 - 1));
            state_q <= DIV_COUNT;
          end
        end
        DIV_COUNT: begin
          if (cnt_q == '0) begin
            state_q <= DIV_CORRECT;  // count exhausted
          end else begin
            cnt_q <= cnt_q >> 1;
          end
        end
        DIV_CORRECT: begin
          done_q  <= 1'b1;
          state_q <= DIV_IDLE;
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  // datapath, no reset
  always_ff @(posedge clk) begin
    if (state_q == DIV_IDLE && start_i) begin
      word_q   <= req_i.is_word;
      z_sign_q <= z_sign;
      s_q      <= s_load;
      d_q      <= d_ext;
      d_neg_q  <= -d_ext;
    end else if (state_q == DIV_COUNT && cnt_q != '0) begin
      s_q <= s_next;
    end
    if (state_q == DIV_CORRECT) begin
      rsp_q.quotient  <= word_q ? {{(XLEN-WLEN){1'b0}}, q_fix[WLEN-1:0]} : q_fix;
      rsp_q.remainder <= word_q ? {{(XLEN-WLEN){1'b0}}, rem_fix[WLEN-1:0]}
                                : rem_fix[XLEN-1:0];
    end
  end

  assign done_o = done_q;
  assign rsp_o  = rsp_q;

  a_start_idle: assert property (@(posedge clk) disable iff (rst)
    start_i |-> state_q == DIV_IDLE);

endmodule

`default_nettype wire

/* hw/m_op_decode.sv */
`default_nettype none
`timescale 1ns/1ns

module m_op_decode import rv_m_pkg::*; import mdu_pkg::*; (
  input  wire logic            start_i,
  input  wire m_op_e           op_i,
  input  wire logic [XLEN-1:0] rs1_i,
  input  wire logic [XLEN-1:0] rs2_i,
  output logic                 div_start_o,
  output div_req_t             div_req_o,
  output logic                 mul_start_o,
  output mul_req_t             mul_req_o,
  output sel_ctl_t             sel_ctl_o
);

  logic is_div;
  logic is_word;
  logic div_signed;
  logic a_signed;
  logic b_signed;
  logic div_zero;
  logic min_neg;
  logic minus_one;

  always_comb begin
    is_div     = 1'b0;
    is_word    = 1'b0;
    div_signed = 1'b0;
    a_signed   = 1'b0;
    b_signed   = 1'b0;
    case (op_i)
      MULH: begin
        a_signed = 1'b1;
        b_signed = 1'b1;
      end
      MULHSU: a_signed = 1'b1;  // rs2 stays unsigned
      DIV, REM: begin
        is_div     = 1'b1;
        div_signed = 1'b1;
      end
      DIVU, REMU: is_div = 1'b1;
      MULW: is_word = 1'b1;  // low half only, sign does not matter
      DIVW, REMW: begin
        is_div     = 1'b1;
        is_word    = 1'b1;
        div_signed = 1'b1;
      end
      DIVUW, REMUW: begin
        is_div  = 1'b1;
        is_word = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // special cases, checked in the width of the operation
  assign div_zero  = is_word ? ~|rs2_i[WLEN-1:0] : ~|rs2_i;
  assign minus_one = is_word ? &rs2_i[WLEN-1:0] : &rs2_i;
  assign min_neg   = is_word ? (rs1_i[WLEN-1:0] == {1'b1, {(WLEN-1){1'b0}}})
                             : (rs1_i == {1'b1, {(XLEN-1){1'b0}}});

  assign div_start_o = start_i & is_div;
  assign mul_start_o = start_i & ~is_div;

  assign div_req_o = '{dividend: rs1_i, divisor: rs2_i, is_signed: div_signed, is_word: is_word};
  assign mul_req_o = '{op_a: rs1_i, op_b: rs2_i, a_signed: a_signed, b_signed: b_signed};

  assign sel_ctl_o = '{op:          op_i,
                       div_by_zero: is_div & div_zero,
                       overflow:    is_div & div_signed & min_neg & minus_one,
                       dividend:    rs1_i};

endmodule

`default_nettype wire

/* hw/mdu_pkg.sv */
`default_nettype none

package mdu_pkg;
  import rv_m_pkg::*;

  localparam int DIV_STEPS64 = 65;  // nonrestoring steps, 64-bit
  localparam int DIV_STEPS32 = 33;  // nonrestoring steps, 32-bit
  localparam int MUL_STEPS   = 64;  // one step per multiplier bit

  typedef struct packed {
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
    logic            is_signed;
    logic            is_word;
  } div_req_t;

  typedef struct packed {
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic            a_signed;
    logic            b_signed;
  } mul_req_t;

  typedef struct packed {
    m_op_e           op;
    logic            div_by_zero;
    logic            overflow;
    logic [XLEN-1:0] dividend;  // remainder on divide by zero
  } sel_ctl_t;

  typedef struct packed {
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
  } div_rsp_t;

  typedef enum logic [1:0] {DIV_RST, DIV_IDLE, DIV_COUNT, DIV_CORRECT} div_state_e;
  typedef enum logic {MUL_IDLE, MUL_RUN} mul_state_e;

endpackage

`default_nettype wire

/* hw/rv_m_pkg.sv */
`default_nettype none

package rv_m_pkg;

  localparam int XLEN = 64;  // 64-bit register width
  localparam int WLEN = 32;  // width of the W-form ops

  // M-extension operations as seen by the unit
  typedef enum logic [3:0] {
    MUL,
    MULH,
    MULHSU,
    MULHU,
    DIV,
    DIVU,
    REM,
    REMU,
    MULW,
    DIVW,
    DIVUW,
    REMW,
    REMUW
  } m_op_e;

endpackage

`default_nettype wire
